// File: soc_bus_pkg.sv
package soc_bus_pkg;

	// Address regions, bits 31:28
	localparam logic [3:0] REGION_RAM  = 4'h0;
	localparam logic [3:0] REGION_UART = 4'h4;
	localparam logic [3:0] REGION_SEG  = 4'h5;

	// External SRAM
	localparam int unsigned SRAM_ADDR_W = 20;
	localparam int unsigned SRAM_WAIT   = 2;   // Strobe cycles per access
	localparam int unsigned SRAM_CNT_W  = $clog2(SRAM_WAIT + 1);
	localparam logic [SRAM_CNT_W-1:0] SRAM_WAIT_LAST = SRAM_CNT_W'(SRAM_WAIT - 1);

	// Serial transmitter
	localparam int unsigned UART_CLKS_PER_BIT = 4;
	localparam int unsigned UART_CNT_W        = $clog2(UART_CLKS_PER_BIT);
	localparam logic [UART_CNT_W-1:0] UART_BAUD_LAST = UART_CNT_W'(UART_CLKS_PER_BIT - 1);

	// Bus address word, seen as memory or as io register space
	typedef union packed {
		struct packed {
			logic [3:0]             region;
			logic [5:0]             rsvd;
			logic [SRAM_ADDR_W-1:0] word;    // SRAM word index
			logic [1:0]             byte_off;
		} mem;
		struct packed {
			logic [3:0]  region;
			logic [19:0] rsvd;
			logic [5:0]  reg_idx;            // Peripheral register
			logic [1:0]  byte_off;
		} io;
	} bus_addr_u;

endpackage

// File: bus_arbiter.sv
module bus_arbiter (
	input  logic        clk,
	input  logic        rst_i,

	input  logic        m0_stb_i,
	input  logic        m0_we_i,
	input  logic [31:0] m0_addr_i,
	input  logic [31:0] m0_wdata_i,
	output logic [31:0] m0_rdata_o,
	output logic        m0_ack_o,

	input  logic        m1_stb_i,
	input  logic        m1_we_i,
	input  logic [31:0] m1_addr_i,
	input  logic [31:0] m1_wdata_i,
	output logic [31:0] m1_rdata_o,
	output logic        m1_ack_o,

	output logic        bus_stb_o,
	output logic        bus_we_o,
	output logic [31:0] bus_addr_o,
	output logic [31:0] bus_wdata_o,
	input  logic [31:0] bus_rdata_i,
	input  logic        bus_ack_i
);

	logic busy;    // Transfer in flight
	logic owner;   // Master holding the bus
	logic last;    // Master served last
	logic pick;
	logic sel;

	// Tie goes to whoever waited
	always_comb begin
		if (m0_stb_i && m1_stb_i)
			pick = ~last;
		else
			pick = m1_stb_i;
	end

	assign sel = busy ? owner : pick;

	assign bus_stb_o   = sel ? m1_stb_i   : m0_stb_i;
	assign bus_we_o    = sel ? m1_we_i    : m0_we_i;
	assign bus_addr_o  = sel ? m1_addr_i  : m0_addr_i;
	assign bus_wdata_o = sel ? m1_wdata_i : m0_wdata_i;

	assign m0_ack_o   = bus_ack_i & ~sel;
	assign m1_ack_o   = bus_ack_i & sel;
	assign m0_rdata_o = sel ? '0 : bus_rdata_i;
	assign m1_rdata_o = sel ? bus_rdata_i : '0;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			busy  <= 1'b0;
			owner <= 1'b0;
			last  <= 1'b1;   // m0 first after reset
		end else if (bus_ack_i) begin
			busy <= 1'b0;
			last <= sel;
		end else if (!busy && bus_stb_o) begin
			busy  <= 1'b1;
			owner <= sel;
		end
	end

endmodule

// File: bus_decoder.sv
module bus_decoder (
	input  logic        clk,
	input  logic        rst_i,

	input  logic        bus_stb_i,
	input  logic [31:0] bus_addr_i,
	output logic [31:0] bus_rdata_o,
	output logic        bus_ack_o,

	output logic        ram_stb_o,
	input  logic [31:0] ram_rdata_i,
	input  logic        ram_ack_i,

	output logic        uart_stb_o,
	input  logic [31:0] uart_rdata_i,
	input  logic        uart_ack_i,

	output logic        seg_stb_o,
	input  logic [31:0] seg_rdata_i,
	input  logic        seg_ack_i
);

	soc_bus_pkg::bus_addr_u addr_u;

	logic sel_ram;
	logic sel_uart;
	logic sel_seg;
	logic sel_none;
	logic none_ack;

	assign addr_u = bus_addr_i;

	always_comb begin
		sel_ram  = 1'b0;
		sel_uart = 1'b0;
		sel_seg  = 1'b0;
		case (addr_u.io.region)
			soc_bus_pkg::REGION_RAM:  sel_ram  = 1'b1;
			// Only register 0 exists in each io region
			soc_bus_pkg::REGION_UART: sel_uart = (addr_u.io.reg_idx == '0);
			soc_bus_pkg::REGION_SEG:  sel_seg  = (addr_u.io.reg_idx == '0);
			default: ;
		endcase
		sel_none = ~(sel_ram | sel_uart | sel_seg);
	end

	assign ram_stb_o  = bus_stb_i & sel_ram;
	assign uart_stb_o = bus_stb_i & sel_uart;
	assign seg_stb_o  = bus_stb_i & sel_seg;

	// Unmapped access acks once and returns zero
	always_ff @(posedge clk) begin
		if (rst_i)
			none_ack <= 1'b0;
		else
			none_ack <= bus_stb_i & sel_none & ~none_ack;
	end

	always_comb begin
		bus_ack_o   = none_ack;
		bus_rdata_o = '0;
		if (sel_ram) begin
			bus_ack_o   = ram_ack_i;
			bus_rdata_o = ram_rdata_i;
		end else if (sel_uart) begin
			bus_ack_o   = uart_ack_i;
			bus_rdata_o = uart_rdata_i;
		end else if (sel_seg) begin
			bus_ack_o   = seg_ack_i;
			bus_rdata_o = seg_rdata_i;
		end
	end

endmodule

// File: sram_ctrl.sv
module sram_ctrl (
	input  logic        clk,
	input  logic        rst_i,

	input  logic        stb_i,
	input  logic        we_i,
	input  logic [31:0] addr_i,
	input  logic [31:0] wdata_i,
	output logic [31:0] rdata_o,
	output logic        ack_o,

	output logic [soc_bus_pkg::SRAM_ADDR_W-1:0] sram_addr_o,
	input  logic [31:0] sram_data_i,
	output logic [31:0] sram_data_o,
	output logic        sram_data_oe_o,
	output logic        sram_ce_n_o,
	output logic        sram_oe_n_o,
	output logic        sram_we_n_o
);

	soc_bus_pkg::bus_addr_u addr_u;

	logic                              active;   // Strobes on the pins
	logic [soc_bus_pkg::SRAM_CNT_W-1:0] wait_cnt;
	logic                              start;
	logic                              done;

	assign addr_u = addr_i;
	assign start  = stb_i & ~active & ~ack_o;   // Idle only
	assign done   = active & (wait_cnt == soc_bus_pkg::SRAM_WAIT_LAST);

	always_ff @(posedge clk) begin
		if (rst_i) begin
			active         <= 1'b0;
			ack_o          <= 1'b0;
			wait_cnt       <= '0;
			sram_ce_n_o    <= 1'b1;
			sram_oe_n_o    <= 1'b1;
			sram_we_n_o    <= 1'b1;
			sram_data_oe_o <= 1'b0;
		end else begin
			ack_o <= done;
			if (start) begin
				active         <= 1'b1;
				wait_cnt       <= '0;
				sram_ce_n_o    <= 1'b0;
				sram_oe_n_o    <= we_i;
				sram_we_n_o    <= ~we_i;
				sram_data_oe_o <= we_i;
			end else if (done) begin
				active      <= 1'b0;
				sram_ce_n_o <= 1'b1;
				sram_oe_n_o <= 1'b1;
				sram_we_n_o <= 1'b1;
			end else if (active) begin
				wait_cnt <= wait_cnt + 1'b1;
			end else begin
				sram_data_oe_o <= 1'b0;   // Write data held through ack
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			sram_addr_o <= addr_u.mem.word;
			sram_data_o <= wdata_i;
		end
		if (done && !sram_oe_n_o)
			rdata_o <= sram_data_i;   // Sample on last wait cycle
	end

endmodule

// File: uart_tx.sv
module uart_tx (
	input  logic        clk,
	input  logic        rst_i,

	input  logic        stb_i,
	input  logic        we_i,
	input  logic [31:0] wdata_i,
	output logic [31:0] rdata_o,
	output logic        ack_o,

	output logic        txd_o
);

	logic                               busy;
	logic [9:0]                         frame;     // Stop, data, start
	logic [soc_bus_pkg::UART_CNT_W-1:0] baud_cnt;
	logic [3:0]                         bit_cnt;
	logic                               accept;

	// Writes wait for the line to go idle
	assign accept = stb_i & ~ack_o & (~we_i | ~busy);
	assign txd_o  = frame[0];

	always_ff @(posedge clk) begin
		if (rst_i) begin
			busy     <= 1'b0;
			ack_o    <= 1'b0;
			frame    <= '1;   // Line idles high
			baud_cnt <= '0;
			bit_cnt  <= '0;
		end else begin
			ack_o <= accept;
			if (accept && we_i) begin
				busy     <= 1'b1;
				frame    <= {1'b1, wdata_i[7:0], 1'b0};
				baud_cnt <= '0;
				bit_cnt  <= '0;
			end else if (busy) begin
				if (baud_cnt == soc_bus_pkg::UART_BAUD_LAST) begin
					baud_cnt <= '0;
					frame    <= {1'b1, frame[9:1]};
					bit_cnt  <= bit_cnt + 1'b1;
					if (bit_cnt == 4'd9)
						busy <= 1'b0;   // Stop bit done
				end else begin
					baud_cnt <= baud_cnt + 1'b1;
				end
			end
		end
	end

	// Status read
	always_ff @(posedge clk) begin
		if (accept)
			rdata_o <= {31'b0, busy};
	end

endmodule

// File: seg_display.sv
module seg_display (
	input  logic        clk,
	input  logic        rst_i,

	input  logic        stb_i,
	input  logic        we_i,
	input  logic [31:0] wdata_i,
	output logic [31:0] rdata_o,
	output logic        ack_o,

	output logic [6:0]  seg_o   // a..g
);

	logic [3:0] digit;

	assign rdata_o = {28'b0, digit};

	always_ff @(posedge clk) begin
		if (rst_i) begin
			ack_o <= 1'b0;
			digit <= 4'h0;
		end else begin
			ack_o <= stb_i & ~ack_o;
			if (stb_i && !ack_o && we_i)
				digit <= wdata_i[3:0];
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			seg_o <= 7'b1111110;
		end else begin
			case (digit)
				4'h0: seg_o <= 7'b1111110;
				4'h1: seg_o <= 7'b0110000;
				4'h2: seg_o <= 7'b1101101;
				4'h3: seg_o <= 7'b1111001;
				4'h4: seg_o <= 7'b0110011;
				4'h5: seg_o <= 7'b1011011;
				4'h6: seg_o <= 7'b1011111;
				4'h7: seg_o <= 7'b1110000;
				4'h8: seg_o <= 7'b1111111;
				4'h9: seg_o <= 7'b1111011;
				4'hA: seg_o <= 7'b1110111;
				4'hB: seg_o <= 7'b0011111;   // Lower case b
				4'hC: seg_o <= 7'b1001110;
				4'hD: seg_o <= 7'b0111101;   // Lower case d
				4'hE: seg_o <= 7'b1001111;
				default: seg_o <= 7'b1000111;
			endcase
		end
	end

endmodule

// File: soc_bus_top.sv
module soc_bus_top (
	input  logic        clk,
	input  logic        rst_i,

	input  logic        m0_stb_i,
	input  logic        m0_we_i,
	input  logic [31:0] m0_addr_i,
	input  logic [31:0] m0_wdata_i,
	output logic [31:0] m0_rdata_o,
	output logic        m0_ack_o,

	input  logic        m1_stb_i,
	input  logic        m1_we_i,
	input  logic [31:0] m1_addr_i,
	input  logic [31:0] m1_wdata_i,
	output logic [31:0] m1_rdata_o,
	output logic        m1_ack_o,

	output logic [soc_bus_pkg::SRAM_ADDR_W-1:0] sram_addr_o,
	input  logic [31:0] sram_data_i,
	output logic [31:0] sram_data_o,
	output logic        sram_data_oe_o,
	output logic        sram_ce_n_o,
	output logic        sram_oe_n_o,
	output logic        sram_we_n_o,

	output logic        uart_txd_o,
	output logic [6:0]  seg_o
);

	// Shared bus
	logic        bus_stb;
	logic        bus_we;
	logic [31:0] bus_addr;
	logic [31:0] bus_wdata;
	logic [31:0] bus_rdata;
	logic        bus_ack;

	logic        ram_stb;
	logic [31:0] ram_rdata;
	logic        ram_ack;
	logic        uart_stb;
	logic [31:0] uart_rdata;
	logic        uart_ack;
	logic        seg_stb;
	logic [31:0] seg_rdata;
	logic        seg_ack;

	bus_arbiter u_arbiter (
		.clk(clk), .rst_i(rst_i),
		.m0_stb_i(m0_stb_i), .m0_we_i(m0_we_i), .m0_addr_i(m0_addr_i),
		.m0_wdata_i(m0_wdata_i), .m0_rdata_o(m0_rdata_o), .m0_ack_o(m0_ack_o),
		.m1_stb_i(m1_stb_i), .m1_we_i(m1_we_i), .m1_addr_i(m1_addr_i),
		.m1_wdata_i(m1_wdata_i), .m1_rdata_o(m1_rdata_o), .m1_ack_o(m1_ack_o),
		.bus_stb_o(bus_stb), .bus_we_o(bus_we), .bus_addr_o(bus_addr),
		.bus_wdata_o(bus_wdata), .bus_rdata_i(bus_rdata), .bus_ack_i(bus_ack)
	);

	bus_decoder u_decoder (
		.clk(clk), .rst_i(rst_i),
		.bus_stb_i(bus_stb), .bus_addr_i(bus_addr),
		.bus_rdata_o(bus_rdata), .bus_ack_o(bus_ack),
		.ram_stb_o(ram_stb), .ram_rdata_i(ram_rdata), .ram_ack_i(ram_ack),
		.uart_stb_o(uart_stb), .uart_rdata_i(uart_rdata), .uart_ack_i(uart_ack),
		.seg_stb_o(seg_stb), .seg_rdata_i(seg_rdata), .seg_ack_i(seg_ack)
	);

	sram_ctrl u_sram (
		.clk(clk), .rst_i(rst_i),
		.stb_i(ram_stb), .we_i(bus_we), .addr_i(bus_addr), .wdata_i(bus_wdata),
		.rdata_o(ram_rdata), .ack_o(ram_ack),
		.sram_addr_o(sram_addr_o), .sram_data_i(sram_data_i),
		.sram_data_o(sram_data_o), .sram_data_oe_o(sram_data_oe_o),
		.sram_ce_n_o(sram_ce_n_o), .sram_oe_n_o(sram_oe_n_o), .sram_we_n_o(sram_we_n_o)
	);

	uart_tx u_uart (
		.clk(clk), .rst_i(rst_i),
		.stb_i(uart_stb), .we_i(bus_we), .wdata_i(bus_wdata),
		.rdata_o(uart_rdata), .ack_o(uart_ack), .txd_o(uart_txd_o)
	);

	seg_display u_seg (
		.clk(clk), .rst_i(rst_i),
		.stb_i(seg_stb), .we_i(bus_we), .wdata_i(bus_wdata),
		.rdata_o(seg_rdata), .ack_o(seg_ack), .seg_o(seg_o)
	);

endmodule

// File: tb_sram_model.sv
module tb_sram_model (
	input  logic [soc_bus_pkg::SRAM_ADDR_W-1:0] addr_i,
	input  logic [31:0] data_i,
	input  logic        data_oe_i,
	output logic [31:0] data_o,
	input  logic        ce_n_i,
	input  logic        oe_n_i,
	input  logic        we_n_i
);

	// Sparse storage, unwritten words read as zero
	logic [31:0] mem [logic [soc_bus_pkg::SRAM_ADDR_W-1:0]];

	// Chip selected with write enable low, data only while the controller drives it
	always @(ce_n_i or we_n_i or addr_i or data_i or data_oe_i) begin
		if (!ce_n_i && !we_n_i && data_oe_i)
			mem[addr_i] = data_i;
	end

	always_comb begin
		data_o = '0;
		if (!ce_n_i && !oe_n_i && mem.exists(addr_i))
			data_o = mem[addr_i];
	end

endmodule

// File: tb_soc_bus.sv
module tb_soc_bus;

	localparam int AW           = soc_bus_pkg::SRAM_ADDR_W;
	localparam int BIT_CLKS     = soc_bus_pkg::UART_CLKS_PER_BIT;
	localparam int ACK_TIMEOUT  = 100;
	localparam int LINE_TIMEOUT = 100;
	localparam logic [31:0] UART_ADDR = {soc_bus_pkg::REGION_UART, 28'h0};
	localparam logic [31:0] SEG_ADDR  = {soc_bus_pkg::REGION_SEG, 28'h0};

	logic          clk;
	logic          rst;
	logic          m0_stb;
	logic          m0_we;
	logic [31:0]   m0_addr;
	logic [31:0]   m0_wdata;
	logic [31:0]   m0_rdata;
	logic          m0_ack;
	logic          m1_stb;
	logic          m1_we;
	logic [31:0]   m1_addr;
	logic [31:0]   m1_wdata;
	logic [31:0]   m1_rdata;
	logic          m1_ack;
	logic [AW-1:0] sram_addr;
	logic [31:0]   sram_rdata;
	logic [31:0]   sram_wdata;
	logic          sram_data_oe;
	logic          sram_ce_n;
	logic          sram_oe_n;
	logic          sram_we_n;
	logic          uart_txd;
	logic [6:0]    seg;

	logic [31:0]   rng_state;
	int            errors;
	int            checks;
	int            timeouts;
	int            ack_seq [$];   // Port of every completed access
	time           ack_time [2];
	time           stop_time;
	logic [31:0]   exp_mem [logic [AW-1:0]];
	logic [AW-1:0] idx_list [$];

	soc_bus_top DUT (
		.clk(clk), .rst_i(rst),
		.m0_stb_i(m0_stb), .m0_we_i(m0_we), .m0_addr_i(m0_addr), .m0_wdata_i(m0_wdata),
		.m0_rdata_o(m0_rdata), .m0_ack_o(m0_ack),
		.m1_stb_i(m1_stb), .m1_we_i(m1_we), .m1_addr_i(m1_addr), .m1_wdata_i(m1_wdata),
		.m1_rdata_o(m1_rdata), .m1_ack_o(m1_ack),
		.sram_addr_o(sram_addr), .sram_data_i(sram_rdata), .sram_data_o(sram_wdata),
		.sram_data_oe_o(sram_data_oe), .sram_ce_n_o(sram_ce_n),
		.sram_oe_n_o(sram_oe_n), .sram_we_n_o(sram_we_n),
		.uart_txd_o(uart_txd), .seg_o(seg)
	);

	tb_sram_model u_sram_chip (
		.addr_i(sram_addr), .data_i(sram_wdata), .data_oe_i(sram_data_oe),
		.data_o(sram_rdata), .ce_n_i(sram_ce_n), .oe_n_i(sram_oe_n), .we_n_i(sram_we_n)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function logic [31:0] next_rand();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	function automatic logic [AW-1:0] rand_index();
		logic [31:0] r;
		r = next_rand();
		return r[AW-1:0];
	endfunction

	// Word index sits in bits 21:2 of a RAM address
	function automatic logic [31:0] ram_addr(input logic [AW-1:0] idx);
		logic [31:0] a;
		a = '0;
		a[AW+1:2] = idx;
		return a;
	endfunction

	// Lit segments per hex glyph with a in bit 6
	function automatic logic [6:0] seg_glyph(input logic [3:0] d);
		string      lit;
		logic [6:0] g;
		int         i;
		int         c;
		case (d)
			4'h0: lit = "abcdef";
			4'h1: lit = "bc";
			4'h2: lit = "abdeg";
			4'h3: lit = "abcdg";
			4'h4: lit = "bcfg";
			4'h5: lit = "acdfg";
			4'h6: lit = "acdefg";
			4'h7: lit = "abc";
			4'h8: lit = "abcdefg";
			4'h9: lit = "abcdfg";
			4'hA: lit = "abcefg";
			4'hB: lit = "cdefg";
			4'hC: lit = "adef";
			4'hD: lit = "bcdeg";
			4'hE: lit = "adefg";
			default: lit = "aefg";
		endcase
		g = '0;
		for (i = 0; i < lit.len(); i++) begin
			c = lit[i] - 8'h61;
			g[6 - c] = 1'b1;
		end
		return g;
	endfunction

	// Round robin with m0 first after reset
	function automatic int expected_winner();
		if (ack_seq.size() == 0)
			return 0;
		return 1 - ack_seq[ack_seq.size() - 1];
	endfunction

	task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic drive_port(input int port, input logic stb, input logic we,
			input logic [31:0] addr, input logic [31:0] wdata);
		if (port == 0) begin
			m0_stb   = stb;
			m0_we    = we;
			m0_addr  = addr;
			m0_wdata = wdata;
		end else begin
			m1_stb   = stb;
			m1_we    = we;
			m1_addr  = addr;
			m1_wdata = wdata;
		end
	endtask

	// Starts on a falling edge and returns on the falling edge after the ack cycle
	task automatic master_access(input int port, input logic we, input logic [31:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata);
		int   cycles;
		logic ack;
		cycles = 0;
		ack    = 1'b0;
		rdata  = '0;
		drive_port(port, 1'b1, we, addr, wdata);
		while (!ack && cycles < ACK_TIMEOUT) begin
			@(negedge clk);
			cycles++;
			ack = (port == 0) ? m0_ack : m1_ack;
		end
		if (ack) begin
			rdata = (port == 0) ? m0_rdata : m1_rdata;
			ack_seq.push_back(port);
			ack_time[port] = $time;
		end else begin
			timeouts++;
			$display("TIMEOUT at %0t: m%0d got no ack for address %h", $time, port, addr);
		end
		drive_port(port, 1'b0, we, addr, wdata);   // Address still selects the acking slave
		@(negedge clk);
	endtask

	task automatic capture_frame(output logic [7:0] data, output logic stop_bit);
		int cycles;
		int i;
		cycles   = 0;
		data     = '0;
		stop_bit = 1'b0;
		while (uart_txd !== 1'b0 && cycles < LINE_TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (uart_txd !== 1'b0) begin
			timeouts++;
			$display("TIMEOUT at %0t: no start bit appeared on the serial line", $time);
			stop_time = $time;
		end else begin
			repeat (BIT_CLKS / 2) @(negedge clk);   // Middle of start bit
			for (i = 0; i < 8; i++) begin
				repeat (BIT_CLKS) @(negedge clk);
				data[i] = uart_txd;
			end
			repeat (BIT_CLKS) @(negedge clk);
			stop_bit  = uart_txd;
			stop_time = $time;
		end
	endtask

	task automatic ram_write(input int port, input logic [AW-1:0] idx, input logic [31:0] data);
		logic [31:0] rd;
		master_access(port, 1'b1, ram_addr(idx), data, rd);
		// Pins keep the last access until the next one starts
		compare("sram address pins", 32'(sram_addr), 32'(idx));
		compare("sram data pins", sram_wdata, data);
		exp_mem[idx] = data;
		idx_list.push_back(idx);
	endtask

	task automatic verify_ram(input string what);
		logic [31:0] rd;
		int          i;
		for (i = 0; i < idx_list.size(); i++) begin
			master_access(0, 1'b0, ram_addr(idx_list[i]), '0, rd);
			compare($sformatf("%s word %h", what, idx_list[i]), rd, exp_mem[idx_list[i]]);
		end
	endtask

	task automatic check_reset_state();
		compare("m0 ack after reset", {31'b0, m0_ack}, 32'd0);
		compare("m1 ack after reset", {31'b0, m1_ack}, 32'd0);
		compare("sram ce_n/oe_n/we_n after reset", {29'b0, sram_ce_n, sram_oe_n, sram_we_n}, 32'd7);
		compare("sram data enable after reset", {31'b0, sram_data_oe}, 32'd0);
		compare("txd after reset", {31'b0, uart_txd}, 32'd1);
		compare("segments after reset", {25'b0, seg}, {25'b0, seg_glyph(4'h0)});
	endtask

	task automatic collide_masters();
		logic [AW-1:0] idx_a;
		logic [AW-1:0] idx_b;
		logic [31:0]   data_a;
		logic [31:0]   data_b;
		logic [31:0]   rd_a;
		logic [31:0]   rd_b;
		int            round;
		int            first;
		int            n;
		for (round = 0; round < 2; round++) begin
			idx_a  = rand_index();
			idx_b  = idx_a ^ 1;   // Never the same word
			data_a = next_rand();
			data_b = next_rand();
			first  = expected_winner();
			n      = ack_seq.size();
			fork
				master_access(0, 1'b1, ram_addr(idx_a), data_a, rd_a);
				master_access(1, 1'b1, ram_addr(idx_b), data_b, rd_b);
			join
			checks++;
			if (ack_seq.size() != n + 2) begin
				errors++;
				$display("ERROR at %0t: collision %0d did not complete both writes", $time, round);
			end else if (ack_seq[n] != first) begin
				errors++;
				$display("MISMATCH at %0t: collision %0d acked m%0d first, expected m%0d",
					$time, round, ack_seq[n], first);
			end
			exp_mem[idx_a] = data_a;
			exp_mem[idx_b] = data_b;
			idx_list.push_back(idx_a);
			idx_list.push_back(idx_b);
			verify_ram("arbitration readback");   // m0 served last before next collision
		end
	endtask

	task automatic sram_round_trip();
		int i;
		for (i = 0; i < 8; i++)
			ram_write(1, rand_index(), next_rand());
		verify_ram("round trip readback");
	endtask

	task automatic send_uart_frame();
		logic [31:0] wdata;
		logic [31:0] rd;
		logic [31:0] busy_rd;
		logic [7:0]  rx;
		logic        stop;
		wdata = next_rand();
		fork
			capture_frame(rx, stop);
			begin
				master_access(1, 1'b1, UART_ADDR, wdata, rd);
				master_access(1, 1'b0, UART_ADDR, '0, busy_rd);
			end
		join
		compare("uart data byte", {24'b0, rx}, {24'b0, wdata[7:0]});
		compare("uart stop bit", {31'b0, stop}, 32'd1);
		compare("uart status during frame", busy_rd, 32'd1);
		repeat (BIT_CLKS) @(negedge clk);   // Rest of the stop bit
		master_access(1, 1'b0, UART_ADDR, '0, rd);
		compare("uart status after frame", rd, 32'd0);
	endtask

	task automatic stall_uart_write();
		logic [31:0] data_a;
		logic [31:0] data_b;
		logic [31:0] rd;
		logic [7:0]  rx_a;
		logic [7:0]  rx_b;
		logic        stop_a;
		logic        stop_b;
		time         first_stop;
		data_a     = next_rand();
		data_b     = next_rand();
		first_stop = 0;
		fork
			begin
				capture_frame(rx_a, stop_a);
				first_stop = stop_time;
				capture_frame(rx_b, stop_b);
			end
			begin
				master_access(1, 1'b1, UART_ADDR, data_a, rd);
				master_access(1, 1'b1, UART_ADDR, data_b, rd);
			end
		join
		checks++;
		if (ack_time[1] <= first_stop) begin
			errors++;
			$display("ERROR at %0t: second uart write acked at %0t, before the stop bit at %0t",
				$time, ack_time[1], first_stop);
		end
		compare("first uart byte", {24'b0, rx_a}, {24'b0, data_a[7:0]});
		compare("first uart stop bit", {31'b0, stop_a}, 32'd1);
		compare("second uart byte", {24'b0, rx_b}, {24'b0, data_b[7:0]});
		compare("second uart stop bit", {31'b0, stop_b}, 32'd1);
		repeat (BIT_CLKS) @(negedge clk);
	endtask

	task automatic cycle_display_digits();
		logic [31:0] wdata;
		logic [31:0] rd;
		int          d;
		for (d = 0; d < 16; d++) begin
			wdata      = next_rand();
			wdata[3:0] = d[3:0];
			master_access(0, 1'b1, SEG_ADDR, wdata, rd);
			master_access(1, 1'b0, SEG_ADDR, '0, rd);
			compare($sformatf("display read for %h", d), rd, d);
			compare($sformatf("segments for %h", d), {25'b0, seg}, {25'b0, seg_glyph(d[3:0])});
		end
	endtask

	task automatic probe_unmapped_region();
		logic [31:0] rd;
		logic [31:0] addr;
		// Same word bits as a stored RAM word but in region 9
		addr        = ram_addr(idx_list[0]);
		addr[31:28] = 4'h9;
		master_access(1, 1'b0, addr, '0, rd);
		compare("unmapped read", rd, 32'd0);
		master_access(1, 1'b1, addr, next_rand(), rd);
		verify_ram("after unmapped write");
	endtask

	initial begin
		rng_state = 32'h1faf_b0dd;
		errors    = 0;
		checks    = 0;
		timeouts  = 0;
		stop_time = 0;
		rst       = 1'b1;
		drive_port(0, 1'b0, 1'b0, '0, '0);
		drive_port(1, 1'b0, 1'b0, '0, '0);
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		check_reset_state();
		collide_masters();
		sram_round_trip();
		send_uart_frame();
		stall_uart_write();
		cycle_display_digits();
		probe_unmapped_region();

		$display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// File: filelist.f
soc_bus_pkg.sv
bus_arbiter.sv
bus_decoder.sv
sram_ctrl.sv
uart_tx.sv
seg_display.sv
soc_bus_top.sv
tb_sram_model.sv
tb_soc_bus.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the SoC bus testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_soc_bus -f filelist.f -o tb_soc_bus
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_soc_bus > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qF '*** PASSED ***' "$log"; then
	exit 0
fi
echo "Pass message not found in $log"
exit 1
